// File: hw/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    // 2 Kbyte device, 11-bit byte address
    localparam int ADDR_W = 11;

    // r/w bit at the end of the control byte
    localparam logic RW_WRITE = 1'b0;
    localparam logic RW_READ  = 1'b1;

    // slot index of the acknowledge bit after eight data bits
    localparam logic [3:0] ACK_SLOT = 4'd8;

    typedef enum logic [3:0] {
        IDLE      = 4'd0,
        START     = 4'd1,
        CTRL_WR   = 4'd2,
        WORD_ADDR = 4'd3,
        DATA_WR   = 4'd4,
        RESTART   = 4'd5,
        CTRL_RD   = 4'd6,
        DATA_RD   = 4'd7,
        STOP      = 4'd8,
        DONE      = 4'd9
    } ctrl_state_t;

    typedef enum logic [1:0] {
        OP_START = 2'd0, // also repeated start
        OP_STOP  = 2'd1,
        OP_WRITE = 2'd2, // 8 bits out, then ack in
        OP_READ  = 2'd3  // 8 bits in, then nack out
    } bit_op_t;

    typedef struct packed {
        logic              is_read;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        wdata;
    } host_req_t;

endpackage

`default_nettype wire

// File: hw/i2c_bit_engine.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_bit_engine
(
    input  wire                 CLK,
    input  wire                 RESET,
    input  wire                 cmd_valid,
    input  wire eeprom_pkg::bit_op_t cmd_op,
    input  wire [7:0]           cmd_byte,
    input  wire                 sda_in,
    output logic                scl,
    output logic                sda_oe,
    output logic                op_done,
    output logic [7:0]          rx_byte,
    output logic                ack_ok
);
    import eeprom_pkg::*;

    logic       active;
    bit_op_t    op_r;
    logic [1:0] q;          // quarter to drive on the next edge
    logic [3:0] slot;
    logic [7:0] shift;
    logic       ack_slot;
    logic [3:0] final_slot;

    // pin levels for one quarter of a slot, returned as {scl, sda_oe}
    function automatic logic [1:0] quarter_out(bit_op_t op, logic [1:0] qtr, logic last,
                                               logic tx_bit);
        logic scl_v;
        logic oe_v;
        scl_v = (qtr == 2'd1) || (qtr == 2'd2);
        case (op)
            OP_START:
                oe_v = (qtr >= 2'd2); // sda falls while scl high
            OP_STOP:
            begin
                scl_v = (qtr != 2'd0); // scl stays high once released
                oe_v  = (qtr <= 2'd1);
            end
            OP_WRITE:
                oe_v = !last && !tx_bit; // ack slot is released
            default:
                oe_v = 1'b0; // read bits and the nack
        endcase
        return {scl_v, oe_v};
    endfunction

    assign ack_slot   = (slot == ACK_SLOT);
    assign final_slot = (op_r == OP_START || op_r == OP_STOP) ? 4'd0 : ACK_SLOT;
    assign rx_byte    = shift;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active  <= 1'b0;
            op_r    <= OP_STOP;
            q       <= 2'd0;
            slot    <= 4'd0;
            scl     <= 1'b1; // bus idle
            sda_oe  <= 1'b0;
            op_done <= 1'b0;
            ack_ok  <= 1'b0;
        end
        else
        begin
            op_done <= 1'b0;
            if (!active)
            begin
                if (cmd_valid)
                begin
                    // quarter 0 goes out on the accepting edge
                    active <= 1'b1;
                    op_r   <= cmd_op;
                    q      <= 2'd1;
                    slot   <= 4'd0;
                    {scl, sda_oe} <= quarter_out(cmd_op, 2'd0, 1'b0, cmd_byte[7]);
                end
            end
            else if (q == 2'd0 && slot > final_slot)
            begin
                active  <= 1'b0;
                op_done <= 1'b1;
            end
            else
            begin
                {scl, sda_oe} <= quarter_out(op_r, q, ack_slot, shift[7]);
                q <= q + 2'd1;
                if (q == 2'd3)
                    slot <= slot + 4'd1;
                if (q == 2'd2 && op_r == OP_WRITE && ack_slot)
                    ack_ok <= !sda_in; // slave pulls low to ack
            end
        end
    end

    // one shifter for both directions
    always_ff @(posedge CLK)
    begin
        if (!active && cmd_valid)
            shift <= cmd_byte;
        else if (active && !ack_slot)
        begin
            if (op_r == OP_READ && q == 2'd2)
                shift <= {shift[6:0], sda_in};
            else if (op_r == OP_WRITE && q == 2'd3)
                shift <= {shift[6:0], 1'b0};
        end
    end

    // data edges fall inside scl low, start and stop excepted
    a_sda_scl_low: assert property (@(posedge CLK) disable iff (RESET)
        $changed(sda_oe) && !(op_r inside {OP_START, OP_STOP}) |-> !scl && !$past(scl))
        else $error("sda_oe changed while scl high");

    a_op_done_pulse: assert property (@(posedge CLK) disable iff (RESET)
        op_done |=> !op_done)
        else $error("op_done wider than one cycle");

endmodule

`default_nettype wire

// File: hw/eeprom_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module eeprom_ctrl
#(
    parameter logic [3:0] DEVICE_CODE = 4'b1010
)
(
    input  wire                   CLK,
    input  wire                   RESET,
    input  wire                   req_valid,
    input  wire eeprom_pkg::host_req_t req,
    input  wire                   op_done,
    input  wire [7:0]             rx_byte,
    input  wire                   ack_ok,
    output logic                  busy,
    output logic                  done,
    output logic                  nack,
    output logic [7:0]            rdata,
    output logic                  cmd_valid,
    output eeprom_pkg::bit_op_t   cmd_op,
    output logic [7:0]            cmd_byte
);
    import eeprom_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;
    host_req_t   req_r;
    logic        wait_op;   // command issued, op_done not yet seen
    logic        nack_pend;

    assign busy      = (state != IDLE);
    assign done      = (state == DONE);
    assign cmd_valid = (state != IDLE) && (state != DONE) && !wait_op;

    // command for the current state and where to go once it completes
    always_comb
    begin
        cmd_op     = OP_WRITE;
        cmd_byte   = 8'hff;
        next_state = state;
        case (state)
            START:
            begin
                cmd_op     = OP_START;
                next_state = CTRL_WR;
            end
            CTRL_WR:
            begin
                cmd_byte   = {DEVICE_CODE, req_r.addr[10:8], RW_WRITE};
                next_state = WORD_ADDR;
            end
            WORD_ADDR:
            begin
                cmd_byte   = req_r.addr[7:0];
                next_state = req_r.is_read ? RESTART : DATA_WR;
            end
            DATA_WR:
            begin
                cmd_byte   = req_r.wdata;
                next_state = STOP;
            end
            RESTART:
            begin
                cmd_op     = OP_START;
                next_state = CTRL_RD;
            end
            CTRL_RD:
            begin
                cmd_byte   = {DEVICE_CODE, req_r.addr[10:8], RW_READ};
                next_state = DATA_RD;
            end
            DATA_RD:
            begin
                cmd_op     = OP_READ; // engine shifts the byte in
                next_state = STOP;
            end
            STOP:
            begin
                cmd_op     = OP_STOP;
                next_state = DONE;
            end
            default:
                cmd_op = OP_STOP;
        endcase
        // no ack on a written byte, close the bus
        if (cmd_op == OP_WRITE && !ack_ok)
            next_state = STOP;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= IDLE;
            wait_op   <= 1'b0;
            nack_pend <= 1'b0;
            nack      <= 1'b0;
        end
        else
        begin
            if (cmd_valid)
                wait_op <= 1'b1;
            case (state)
                IDLE:
                    if (req_valid)
                    begin
                        state     <= START;
                        nack_pend <= 1'b0;
                    end
                DONE:
                    state <= IDLE;
                default:
                    if (op_done)
                    begin
                        wait_op <= 1'b0;
                        state   <= next_state;
                        if (cmd_op == OP_WRITE && !ack_ok)
                            nack_pend <= 1'b1;
                        if (state == STOP)
                            nack <= nack_pend; // holds until the next done
                    end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == IDLE && req_valid)
            req_r <= req;
    end

    always_ff @(posedge CLK)
    begin
        if (state == DATA_RD && op_done)
            rdata <= rx_byte;
    end

    // engine only finishes what was issued
    a_one_in_flight: assert property (@(posedge CLK) disable iff (RESET)
        op_done |-> wait_op)
        else $error("op_done without an outstanding command");

    a_done_pulse: assert property (@(posedge CLK) disable iff (RESET)
        done |=> !done)
        else $error("done wider than one cycle");

endmodule

`default_nettype wire

// File: hw/eeprom_top.sv
`timescale 1ns/1ns
`default_nettype none

module eeprom_top
#(
    parameter logic [3:0] DEVICE_CODE = 4'b1010
)
(
    input  wire                          CLK,
    input  wire                          RESET,
    input  wire                          wr,
    input  wire                          rd,
    input  wire [eeprom_pkg::ADDR_W-1:0] addr,
    input  wire [7:0]                    wdata,
    input  wire                          sda_in,
    output logic [7:0]                   rdata,
    output logic                         busy,
    output logic                         done,
    output logic                         nack,
    output logic                         scl,
    output logic                         sda_oe
);
    import eeprom_pkg::*;

    host_req_t  req;
    logic       req_valid;
    logic       cmd_valid;
    bit_op_t    cmd_op;
    logic [7:0] cmd_byte;
    logic       op_done;
    logic [7:0] rx_byte;
    logic       ack_ok;

    // wr wins when both strobes are high
    assign req_valid = wr || rd;
    assign req = '{is_read: !wr, addr: addr, wdata: wdata};

    eeprom_ctrl #(
        .DEVICE_CODE (DEVICE_CODE)
    ) i_ctrl (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .op_done   (op_done),
        .rx_byte   (rx_byte),
        .ack_ok    (ack_ok),
        .busy      (busy),
        .done      (done),
        .nack      (nack),
        .rdata     (rdata),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_byte  (cmd_byte)
    );

    i2c_bit_engine i_bit_engine (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_byte  (cmd_byte),
        .sda_in    (sda_in),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .op_done   (op_done),
        .rx_byte   (rx_byte),
        .ack_ok    (ack_ok)
    );

endmodule

`default_nettype wire

// File: sim/eeprom_model.sv
`timescale 1ns/1ns
`default_nettype none

module eeprom_model
(
    input  wire  CLK,
    input  wire  scl,
    input  wire  sda,
    input  wire  ack_enable,
    output logic sda_pd
);
    typedef enum logic [2:0] {
        M_IDLE,
        M_RX,    // byte coming in from the master
        M_ACK,   // holding sda low for the ack
        M_TX,    // read data going out
        M_TXACK  // master ack or nack slot
    } model_state_t;

    logic [7:0]   mem [0:2047];
    model_state_t st;
    logic         prev_scl;
    logic         prev_sda;
    logic [3:0]   bit_cnt;
    logic [7:0]   rx_sr;
    logic [7:0]   tx_byte;
    logic         last_bit;
    logic [1:0]   byte_idx; // 0 control, 1 word address, 2 data
    logic         rd_mode;
    logic [10:0]  ptr;
    int           proto_errors;
    int           i;

    logic rise;
    logic fall;
    logic start_seen;
    logic stop_seen;

    // bus oversampled on CLK
    assign rise       = scl && !prev_scl;
    assign fall       = !scl && prev_scl;
    assign start_seen = scl && prev_scl && prev_sda && !sda;
    assign stop_seen  = scl && prev_scl && !prev_sda && sda;

    initial
    begin
        for (i = 0; i < 2048; i++)
            mem[i] = 8'hff; // erased device
        st           = M_IDLE;
        prev_scl     = 1'b1;
        prev_sda     = 1'b1;
        bit_cnt      = 4'd0;
        byte_idx     = 2'd0;
        rd_mode      = 1'b0;
        ptr          = 11'd0;
        sda_pd       = 1'b0;
        proto_errors = 0;
    end

    always @(posedge CLK)
    begin
        prev_scl <= scl;
        prev_sda <= sda;
        if (start_seen)
        begin
            st       <= M_RX;
            bit_cnt  <= 4'd0;
            byte_idx <= 2'd0;
            sda_pd   <= 1'b0;
        end
        else if (stop_seen)
            st <= M_IDLE;
        else if (rise)
        begin
            case (st)
                M_RX:
                begin
                    rx_sr    <= {rx_sr[6:0], sda};
                    last_bit <= sda;
                    bit_cnt  <= bit_cnt + 4'd1;
                end
                M_TX:
                    bit_cnt <= bit_cnt + 4'd1;
                M_TXACK:
                    // a single-byte read always ends with a nack
                    assert (sda)
                    else
                    begin
                        proto_errors <= proto_errors + 1;
                        $display("[ERROR] %0t: master acked the last read byte", $time);
                    end
                default:
                    ;
            endcase
        end
        else if (fall)
        begin
            case (st)
                M_RX:
                begin
                    if (bit_cnt != 4'd0)
                        assert (prev_sda == last_bit)
                        else
                        begin
                            proto_errors <= proto_errors + 1;
                            $display("[ERROR] %0t: master sda moved while scl high", $time);
                        end
                    if (bit_cnt == 4'd8)
                    begin
                        if (!ack_enable || (byte_idx == 2'd0 && rx_sr[7:4] != 4'b1010))
                            st <= M_IDLE; // not for us, or acks switched off
                        else
                        begin
                            sda_pd <= 1'b1;
                            st     <= M_ACK;
                            case (byte_idx)
                                2'd0:
                                begin
                                    ptr[10:8] <= rx_sr[3:1]; // block select bits
                                    rd_mode   <= rx_sr[0];
                                end
                                2'd1:
                                    ptr[7:0] <= rx_sr;
                                default:
                                begin
                                    mem[ptr] <= rx_sr;
                                    ptr[7:0] <= ptr[7:0] + 8'd1;
                                end
                            endcase
                        end
                    end
                end
                M_ACK:
                begin
                    bit_cnt <= 4'd0;
                    if (rd_mode)
                    begin
                        st      <= M_TX;
                        tx_byte <= mem[ptr];
                        sda_pd  <= !mem[ptr][7]; // msb right after the ack
                    end
                    else
                    begin
                        st     <= M_RX;
                        sda_pd <= 1'b0;
                        if (byte_idx != 2'd2)
                            byte_idx <= byte_idx + 2'd1;
                    end
                end
                M_TX:
                    if (bit_cnt == 4'd8)
                    begin
                        sda_pd <= 1'b0;
                        st     <= M_TXACK;
                    end
                    else
                        sda_pd <= !tx_byte[3'd7 - bit_cnt[2:0]];
                M_TXACK:
                    st <= M_IDLE;
                default:
                    ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_eeprom.sv
`timescale 1ns/1ns
`default_nettype none

module tb_eeprom;
    import eeprom_pkg::*;

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        wdata;
    logic [7:0]        rdata;
    logic              busy;
    logic              done;
    logic              nack;
    logic              scl;
    logic              sda_oe;
    logic              model_pd;
    logic              ack_enable;
    wire               sda;

    logic [7:0]  ref_mem [0:2047];
    logic        written [0:2047];
    logic [31:0] rng;
    int          errors;
    int          tests_passed;
    int          tests_failed;
    int          errors_at_start;

    assign sda = !(sda_oe || model_pd); // wired-AND with pull-up

    eeprom_top #(
        .DEVICE_CODE (4'b1010)
    ) i_eeprom_top (
        .CLK    (CLK),
        .RESET  (RESET),
        .wr     (wr),
        .rd     (rd),
        .addr   (addr),
        .wdata  (wdata),
        .sda_in (sda),
        .rdata  (rdata),
        .busy   (busy),
        .done   (done),
        .nack   (nack),
        .scl    (scl),
        .sda_oe (sda_oe)
    );

    eeprom_model i_model (
        .CLK        (CLK),
        .scl        (scl),
        .sda        (sda),
        .ack_enable (ack_enable),
        .sda_pd     (model_pd)
    );

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_random(output logic [31:0] r);
        rng = xorshift32(rng);
        r   = rng;
    endtask

    function int total_errors();
        return errors + i_model.proto_errors;
    endfunction

    task automatic begin_test();
        errors_at_start = total_errors();
    endtask

    task automatic end_test(input string name);
        if (total_errors() == errors_at_start)
        begin
            tests_passed++;
            $display("test %s: pass", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: FAIL", name);
        end
    endtask

    task automatic issue_request(input logic is_rd, input logic [ADDR_W-1:0] a,
                                 input logic [7:0] d);
        @(negedge CLK);
        wr    = !is_rd;
        rd    = is_rd;
        addr  = a;
        wdata = d;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_for_done(output logic seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < 300)
        begin
            @(negedge CLK);
            seen = done;
            n++;
        end
        if (!seen)
        begin
            errors++;
            $display("timeout: no done pulse within 300 cycles at %0t", $time);
        end
    endtask

    task automatic count_done_pulses(input int cycles, output int n);
        int c;
        n = 0;
        c = 0;
        while (c < cycles)
        begin
            @(negedge CLK);
            if (done)
                n++;
            c++;
        end
    endtask

    task automatic transact(input logic is_rd, input logic [ADDR_W-1:0] a,
                            input logic [7:0] d, output logic [7:0] got,
                            output logic got_nack);
        logic seen;
        issue_request(is_rd, a, d);
        wait_for_done(seen);
        got      = seen ? rdata : 8'h00;
        got_nack = seen ? nack : 1'b1;
    endtask

    task automatic write_byte(input logic [ADDR_W-1:0] a, input logic [7:0] d);
        logic [7:0] got;
        logic       got_nack;
        transact(1'b0, a, d, got, got_nack);
        assert (!got_nack)
        else
        begin
            errors++;
            $display("[ERROR] %0t: write to %h not acknowledged", $time, a);
        end
        if (!got_nack)
        begin
            ref_mem[a] = d;
            written[a] = 1'b1;
        end
    endtask

    task automatic check_read(input logic [ADDR_W-1:0] a, output logic [7:0] got);
        logic got_nack;
        transact(1'b1, a, 8'h00, got, got_nack);
        assert (!got_nack && got == ref_mem[a])
        else
        begin
            errors++;
            $display("[ERROR] %0t: read at %h gave %h nack %b, expected %h",
                     $time, a, got, got_nack, ref_mem[a]);
        end
    endtask

    initial
    begin
        logic [31:0]       r;
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] b;
        logic [7:0]        got;
        logic              got_nack;
        logic              seen;
        int                extra;
        int                tries;
        int                i;

        RESET      = 1'b1;
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = '0;
        wdata      = 8'h00;
        ack_enable = 1'b1;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        rng          = 32'd75;
        for (i = 0; i < 2048; i++)
        begin
            ref_mem[i] = 8'hff;
            written[i] = 1'b0;
        end
        repeat (4) @(negedge CLK);
        RESET = 1'b0;

        begin_test();
        @(negedge CLK);
        assert (scl === 1'b1 && sda_oe === 1'b0 && busy === 1'b0 && done === 1'b0
                && nack === 1'b0)
        else
        begin
            errors++;
            $display("[ERROR] %0t: outputs not idle after reset", $time);
        end
        end_test("reset state");

        begin_test();
        write_byte(11'h2a5, 8'h5c);
        check_read(11'h2a5, got);
        end_test("write then read");

        begin_test();
        for (i = 0; i < 12; i++)
        begin
            next_random(r);
            a = {i[2:0], r[7:0]}; // walks every block select value
            write_byte(a, r[15:8]);
            check_read(a, got);
            next_random(r);
            b     = r[10:0];
            tries = 0;
            while (written[b] && tries < 16)
            begin
                next_random(r);
                b = r[10:0];
                tries++;
            end
            check_read(b, got);
            assert (written[b] || got == 8'hff)
            else
            begin
                errors++;
                $display("[ERROR] %0t: unwritten %h read as %h", $time, b, got);
            end
        end
        end_test("random addresses");

        begin_test();
        write_byte(11'h5e1, 8'h22);
        write_byte(11'h5e0, 8'h11);
        write_byte(11'h5e0, 8'h33);
        check_read(11'h5e0, got);
        check_read(11'h5e1, got);
        end_test("overwrite");

        begin_test();
        @(negedge CLK);
        ack_enable = 1'b0;
        transact(1'b0, 11'h2a5, 8'ha7, got, got_nack);
        assert (got_nack)
        else
        begin
            errors++;
            $display("[ERROR] %0t: nack low without an acknowledge", $time);
        end
        @(negedge CLK);
        ack_enable = 1'b1;
        check_read(11'h2a5, got);
        end_test("missing acknowledge");

        begin_test();
        a = 11'h123;
        b = 11'h124;
        issue_request(1'b0, a, 8'h6d);
        @(negedge CLK);
        assert (busy)
        else
        begin
            errors++;
            $display("[ERROR] %0t: busy low during a write", $time);
        end
        wr    = 1'b1; // both strobes land while busy
        addr  = b;
        wdata = 8'h99;
        @(negedge CLK);
        wr   = 1'b0;
        rd   = 1'b1;
        addr = a;
        @(negedge CLK);
        rd = 1'b0;
        wait_for_done(seen);
        if (seen && !nack)
        begin
            ref_mem[a] = 8'h6d;
            written[a] = 1'b1;
        end
        count_done_pulses(250, extra);
        assert (seen && !nack && extra == 0)
        else
        begin
            errors++;
            $display("[ERROR] %0t: %0d extra done pulses, nack %b", $time, extra, nack);
        end
        check_read(a, got);
        check_read(b, got);
        end_test("busy strobes");

        $display("tests: %0d passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0 && total_errors() == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
hw/eeprom_pkg.sv
hw/i2c_bit_engine.sv
hw/eeprom_ctrl.sv
hw/eeprom_top.sv
sim/eeprom_model.sv
sim/tb_eeprom.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_eeprom
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
